//--- src.f
+incdir+src
src/minimig_pkg.sv
src/amiga_clk_en.sv
src/user_io.sv
src/mem_arbiter.sv
src/chip_ram.sv
src/minimig_mist_top.sv
tests/tb_clk_gen.sv
tests/tb_minimig_mist_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
verilator --binary --timing --assert -Wno-fatal -f src.f \
  --top-module tb_minimig_mist_top -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

//--- tests/tb_minimig_mist_top.sv
/*
  testbench for minimig_mist_top, inputs change on the falling edge
  random memory traffic stays on 16 pre-filled words
*/
`timescale 1ns/10ps
`include "minimig_config.svh"

module tb_minimig_mist_top import minimig_pkg::*; ();

  localparam int PAYLOADS     = 3;                      // payload bytes per frame
  localparam int BYTE_CYCLES  = 64;                     // 8 bits at clk/8
  localparam int FRAME_CYCLES = 25 + (PAYLOADS + 1) * BYTE_CYCLES;
  localparam int MEM_OPS      = 400;
  // reset, free run, frames, stall, fill, traffic, drain
  localparam int TEST_CYCLES  = 16 + 60 + 6 * FRAME_CYCLES + 30 + 16 + MEM_OPS + 6;

  logic clk, rst, armed;
  logic spi_sck, spi_di, conf_data0, spi_do, spi_do_oe;
  joy_t joy_a, joy_b;
  logic [2:0] mouse_buttons;
  kbd_mouse_t kbd_mouse;
  logic kbd_mouse_valid, kbd_mouse_ready;
  logic clk7_en, clk7n_en, c1, c3, cck, eclk;
  mem_req_t chip_req, cpu_req;
  logic chip_valid, chip_ready, chip_rsp_valid;
  logic cpu_valid, cpu_ready, cpu_rsp_valid;
  mem_rsp_t chip_rsp, cpu_rsp;

  logic [31:0] rng = 32'd82985;
  int          post_cnt = 0;            // edges since reset release
  logic [1:0]  ss_ref;                  // select as seen after 2 flops
  logic        id_mark = 1'b0;
  logic [7:0]  id_rx;
  logic        byte_mark = 1'b0;        // final rising sck of a payload byte
  joy_t        exp_joy_a = '0;
  joy_t        exp_joy_b = '0;
  logic [2:0]  exp_btn = '0;
  kbd_mouse_t  km_mem [32];             // expected stream, in order
  kbd_mouse_t  km_head;
  int          wr_ptr = 0;
  int          rd_ptr = 0;
  mem_data_t   shadow [16];
  logic        e1_v, e1_chip, e2_v, e2_chip;   // expected response timeline
  mem_data_t   e1_data, e2_data;
  mem_req_t    acc;

  tb_clk_gen clk_gen (.clk(clk), .rst(rst));

  minimig_mist_top dut (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [5:0] exp_enables(input int n);
    int k;
    if (n == 0) return 6'd0;    // nothing before the first free edge
    k = n - 1;
    return {k % 4 == 0, k % 4 == 2, k % 4 == 1 || k % 4 == 2,
            k % 4 == 2 || k % 4 == 3, k % 8 == 0, k % 40 == 0};
  endfunction

  function automatic mem_data_t fill_word(input mem_addr_t a);
    return {a[7:0] ^ 8'h3c, a[11:4]} ^ 16'h5a5a;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
    fail_run("value mismatch");
  endtask

  //////////////////////////////////////////////////
  // reference state updated on the rising edge
  //////////////////////////////////////////////////

  initial armed = 1'b0;
  always @(posedge clk) armed <= 1'b1;  // registers are reset from here on

  always @(posedge clk) begin
    if (rst) begin
      post_cnt <= 0;
      ss_ref   <= 2'b11;
    end else begin
      post_cnt <= post_cnt + 1;
      ss_ref   <= {ss_ref[0], conf_data0};
    end
  end

  always_comb km_head = km_mem[rd_ptr % 32];

  always @(posedge clk) begin
    if (!rst && kbd_mouse_valid && kbd_mouse_ready) rd_ptr <= rd_ptr + 1;
  end

  always @(posedge clk) begin
    if (rst) begin
      e1_v <= 1'b0;
      e2_v <= 1'b0;
    end else begin
      e2_v    <= e1_v;
      e2_chip <= e1_chip;
      e2_data <= e1_data;
      e1_v    <= 1'b0;
      if (chip_valid || cpu_valid) begin
        acc = chip_valid ? chip_req : cpu_req;   // chip has priority
        if (acc.we) begin
          if (acc.be[0]) shadow[acc.addr[11:8]][7:0] = acc.wdata[7:0];
          if (acc.be[1]) shadow[acc.addr[11:8]][15:8] = acc.wdata[15:8];
        end else begin
          e1_v    <= 1'b1;
          e1_chip <= chip_valid;
          e1_data <= shadow[acc.addr[11:8]];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_reset_idle: assert property (@(posedge clk) (armed && rst) |->
    !(clk7_en || clk7n_en || cck || eclk || kbd_mouse_valid || chip_rsp_valid ||
      cpu_rsp_valid || spi_do_oe || joy_a != 0 || joy_b != 0 || mouse_buttons != 0))
    else fail_run("an output was active during reset");

  a_enables: assert property (@(posedge clk) armed |->
    {clk7_en, clk7n_en, c1, c3, cck, eclk} == exp_enables(post_cnt))
    else report_mismatch("{clk7_en,clk7n_en,c1,c3,cck,eclk}",
      32'(exp_enables($sampled(post_cnt))),
      32'($sampled({clk7_en, clk7n_en, c1, c3, cck, eclk})));

  a_oe: assert property (@(posedge clk) armed |-> spi_do_oe == !ss_ref[1])
    else report_mismatch("spi_do_oe", !$sampled(ss_ref[1]), $sampled(spi_do_oe));

  a_core_id: assert property (@(posedge clk) id_mark |-> id_rx == `CORE_ID)
    else report_mismatch("spi_do", `CORE_ID, $sampled(id_rx));

  a_joy_a: assert property (@(posedge clk) byte_mark |-> ##3 joy_a == exp_joy_a)
    else report_mismatch("joy_a", $sampled(exp_joy_a), $sampled(joy_a));
  a_joy_b: assert property (@(posedge clk) byte_mark |-> ##3 joy_b == exp_joy_b)
    else report_mismatch("joy_b", $sampled(exp_joy_b), $sampled(joy_b));
  a_btn: assert property (@(posedge clk) byte_mark |-> ##3 mouse_buttons == exp_btn)
    else report_mismatch("mouse_buttons", $sampled(exp_btn), $sampled(mouse_buttons));

  a_km_order: assert property (@(posedge clk) disable iff (rst)
    (kbd_mouse_valid && kbd_mouse_ready) |-> (rd_ptr != wr_ptr && kbd_mouse == km_head))
    else report_mismatch("kbd_mouse", $sampled(km_head), $sampled(kbd_mouse));
  a_km_stall: assert property (@(posedge clk) disable iff (rst)
    (kbd_mouse_valid && !kbd_mouse_ready) |=> kbd_mouse_valid && $stable(kbd_mouse))
    else fail_run("kbd_mouse dropped or changed while stalled");

  a_chip_ready: assert property (@(posedge clk) armed |-> chip_ready)
    else report_mismatch("chip_ready", 1, $sampled(chip_ready));
  a_cpu_ready: assert property (@(posedge clk) armed |-> cpu_ready == !chip_valid)
    else report_mismatch("cpu_ready", !$sampled(chip_valid), $sampled(cpu_ready));

  a_chip_rv: assert property (@(posedge clk) armed |-> chip_rsp_valid == (e2_v && e2_chip))
    else report_mismatch("chip_rsp_valid", $sampled(e2_v && e2_chip), $sampled(chip_rsp_valid));
  a_cpu_rv: assert property (@(posedge clk) armed |-> cpu_rsp_valid == (e2_v && !e2_chip))
    else report_mismatch("cpu_rsp_valid", $sampled(e2_v && !e2_chip), $sampled(cpu_rsp_valid));
  a_chip_rd: assert property (@(posedge clk) (e2_v && e2_chip) |-> chip_rsp.rdata == e2_data)
    else report_mismatch("chip_rsp.rdata", $sampled(e2_data), $sampled(chip_rsp.rdata));
  a_cpu_rd: assert property (@(posedge clk) (e2_v && !e2_chip) |-> cpu_rsp.rdata == e2_data)
    else report_mismatch("cpu_rsp.rdata", $sampled(e2_data), $sampled(cpu_rsp.rdata));

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic note_payload(input logic [7:0] cmd, input logic [7:0] b);
    case (cmd)
      `CMD_JOY_A:     exp_joy_a = b[5:0];
      `CMD_JOY_B:     exp_joy_b = b[5:0];
      `CMD_MOUSE_BTN: exp_btn   = b[2:0];
      `CMD_MOUSE, `CMD_KBD: begin
        if (kbd_mouse_ready || wr_ptr == rd_ptr) begin   // hold free
          km_mem[wr_ptr % 32] = {b, (cmd == `CMD_KBD) ? KM_KBD : KM_MOUSE};
          wr_ptr = wr_ptr + 1;
        end
      end
      default: ;
    endcase
  endtask

  // one mode 0 byte, sck at clk/8, miso taken as sck rises
  task automatic spi_byte(input logic [7:0] tx, input logic pay, input logic [7:0] cmd,
                          output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      spi_sck = 1'b0;
      spi_di  = tx[i];
      repeat (4) @(negedge clk);
      rx = {rx[6:0], spi_do};
      spi_sck = 1'b1;
      if (i == 0 && pay) begin
        note_payload(cmd, tx);
        byte_mark = 1'b1;
      end
      @(negedge clk);
      byte_mark = 1'b0;
      repeat (3) @(negedge clk);
    end
    spi_sck = 1'b0;
  endtask

  task automatic spi_frame(input logic [7:0] cmd, input int n);
    logic [7:0] rx;
    conf_data0 = 1'b0;
    repeat (8) @(negedge clk);          // id loaded before the first edge
    spi_byte(cmd, 1'b0, cmd, rx);
    id_rx   = rx;
    id_mark = 1'b1;
    @(negedge clk);
    id_mark = 1'b0;
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      spi_byte(rng[7:0], 1'b1, cmd, rx);
    end
    repeat (8) @(negedge clk);
    conf_data0 = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic mem_traffic(input int n);
    for (int i = 0; i < n; i++) begin
      rng = xorshift32(rng);
      chip_valid = rng[0] & rng[1];
      cpu_valid  = rng[2];
      chip_req   = '{addr: {rng[11:8], 8'hc3}, wdata: rng[31:16], be: rng[5:4], we: rng[3]};
      cpu_req    = '{addr: {rng[15:12], 8'hc3}, wdata: ~rng[31:16], be: rng[7:6],
                     we: rng[6] ^ rng[9]};
      @(negedge clk);
    end
    chip_valid = 1'b0;
    cpu_valid  = 1'b0;
  endtask

  initial begin
    spi_sck = 1'b0;
    spi_di = 1'b0;
    conf_data0 = 1'b1;
    kbd_mouse_ready = 1'b1;
    chip_req = '0;
    cpu_req = '0;
    chip_valid = 1'b0;
    cpu_valid = 1'b0;
    wait (!rst);
    repeat (60) @(negedge clk);         // free run for the enable checks
    spi_frame(`CMD_JOY_A, PAYLOADS);
    spi_frame(`CMD_JOY_B, PAYLOADS);
    spi_frame(`CMD_MOUSE_BTN, PAYLOADS);
    spi_frame(`CMD_MOUSE, PAYLOADS);
    spi_frame(`CMD_KBD, PAYLOADS);
    kbd_mouse_ready = 1'b0;             // first byte held, rest dropped
    spi_frame(`CMD_KBD, PAYLOADS);
    repeat (20) @(negedge clk);
    kbd_mouse_ready = 1'b1;
    repeat (10) @(negedge clk);
    for (int i = 0; i < 16; i++) begin
      chip_valid = 1'b1;
      chip_req   = '{addr: {4'(i), 8'hc3}, wdata: fill_word({4'(i), 8'hc3}), be: 2'b11,
                     we: 1'b1};
      @(negedge clk);
    end
    mem_traffic(MEM_OPS);
    repeat (6) @(negedge clk);          // drain the response pipeline
    if (rd_ptr != wr_ptr) begin
      fail_run("stream bytes were never transferred");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

  initial begin
    repeat (2 * TEST_CYCLES) @(posedge clk);
    fail_run("watchdog expired, the test did not finish in time");
  end

endmodule

//--- tests/tb_clk_gen.sv
/*
  40 ns clock, rst high for the first 16 rising edges
  rst drops on a falling edge
*/
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 25 MHz stand-in for the 28 MHz clock
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- src/minimig_mist_top.sv
/*
  core glue of the minimig board port, single 28 MHz clock
  spi_do is driven only while spi_do_oe is high
*/
`timescale 1ns/10ps

module minimig_mist_top import minimig_pkg::*; (
  input  logic       clk,              // 28 MHz
  input  logic       rst,
  // spi from the board controller
  input  logic       spi_sck,
  input  logic       spi_di,
  input  logic       conf_data0,
  output logic       spi_do,
  output logic       spi_do_oe,
  // user inputs
  output joy_t       joy_a,
  output joy_t       joy_b,
  output logic [2:0] mouse_buttons,
  output kbd_mouse_t kbd_mouse,
  output logic       kbd_mouse_valid,
  input  logic       kbd_mouse_ready,
  // clock enables
  output logic       clk7_en,
  output logic       clk7n_en,
  output logic       c1,
  output logic       c3,
  output logic       cck,
  output logic       eclk,
  // memory ports
  input  mem_req_t   chip_req,
  input  logic       chip_valid,
  output logic       chip_ready,
  output mem_rsp_t   chip_rsp,
  output logic       chip_rsp_valid,
  input  mem_req_t   cpu_req,
  input  logic       cpu_valid,
  output logic       cpu_ready,
  output mem_rsp_t   cpu_rsp,
  output logic       cpu_rsp_valid
);

  mem_req_t  ram_req;
  logic      ram_en;
  mem_data_t ram_rdata;

  //////////////////////////////////////////////////
  // clock enables and user io
  //////////////////////////////////////////////////

  amiga_clk_en amiga_clk_en (
    .clk      (clk     ),
    .rst      (rst     ),
    .clk7_en  (clk7_en ),
    .clk7n_en (clk7n_en),
    .c1       (c1      ),
    .c3       (c3      ),
    .cck      (cck     ),
    .eclk     (eclk    )
  );

  user_io user_io (
    .clk             (clk            ),
    .rst             (rst            ),
    .spi_sck         (spi_sck        ),
    .spi_di          (spi_di         ),
    .conf_data0      (conf_data0     ),
    .kbd_mouse_ready (kbd_mouse_ready),
    .spi_do          (spi_do         ),
    .spi_do_oe       (spi_do_oe      ),
    .joy_a           (joy_a          ),
    .joy_b           (joy_b          ),
    .mouse_buttons   (mouse_buttons  ),
    .kbd_mouse       (kbd_mouse      ),
    .kbd_mouse_valid (kbd_mouse_valid)
  );

  //////////////////////////////////////////////////
  // memory subsystem
  //////////////////////////////////////////////////

  mem_arbiter mem_arbiter (
    .clk            (clk           ),
    .rst            (rst           ),
    .chip_req       (chip_req      ),
    .chip_valid     (chip_valid    ),
    .chip_ready     (chip_ready    ),
    .cpu_req        (cpu_req       ),
    .cpu_valid      (cpu_valid     ),
    .cpu_ready      (cpu_ready     ),
    .ram_req        (ram_req       ),
    .ram_en         (ram_en        ),
    .ram_rdata      (ram_rdata     ),
    .chip_rsp       (chip_rsp      ),
    .chip_rsp_valid (chip_rsp_valid),
    .cpu_rsp        (cpu_rsp       ),
    .cpu_rsp_valid  (cpu_rsp_valid )
  );

  chip_ram chip_ram (
    .clk       (clk      ),
    .ram_req   (ram_req  ),
    .ram_en    (ram_en   ),
    .ram_rdata (ram_rdata)   // one cycle behind ram_en
  );

endmodule

//--- src/chip_ram.sv
/*
  behavioural stand-in for the sdram, one access per clock
  registered read, contents undefined until written
*/
`timescale 1ns/10ps
`include "minimig_config.svh"

module chip_ram import minimig_pkg::*; (
  input  logic      clk,
  input  mem_req_t  ram_req,
  input  logic      ram_en,
  output mem_data_t ram_rdata   // valid the cycle after ram_en
);

  localparam int unsigned DEPTH = 1 << `MEM_ADDR_W;

  mem_data_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (ram_en) begin
      if (ram_req.we) begin
        if (ram_req.be[0]) begin
          mem[ram_req.addr][7:0] <= ram_req.wdata[7:0];     // lower byte
        end
        if (ram_req.be[1]) begin
          mem[ram_req.addr][15:8] <= ram_req.wdata[15:8];   // upper byte
        end
      end else begin
        ram_rdata <= mem[ram_req.addr];
      end
    end
  end

endmodule

//--- src/mem_arbiter.sv
/*
  fixed priority arbiter, chip dma always wins over the cpu
  read data returns 2 cycles after acceptance, writes return nothing
*/
`timescale 1ns/10ps

module mem_arbiter import minimig_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  mem_req_t  chip_req,
  input  logic      chip_valid,
  output logic      chip_ready,
  input  mem_req_t  cpu_req,
  input  logic      cpu_valid,
  output logic      cpu_ready,
  output mem_req_t  ram_req,
  output logic      ram_en,
  input  mem_data_t ram_rdata,
  output mem_rsp_t  chip_rsp,
  output logic      chip_rsp_valid,
  output mem_rsp_t  cpu_rsp,
  output logic      cpu_rsp_valid
);

  arb_owner_t grant;       // port issued this cycle
  arb_owner_t rd_owner;    // grant, reads only
  arb_owner_t tag_ram;     // read sitting in chip_ram
  arb_owner_t tag_rsp;     // read sitting in the response register
  mem_data_t  rdata_q;

  //////////////////////////////////////////////////
  // grant and issue
  //////////////////////////////////////////////////

  always_comb begin
    grant = NONE;
    if (chip_valid) begin
      grant = CHIP;
    end else if (cpu_valid) begin
      grant = CPU;
    end
  end

  assign chip_ready = 1'b1;                     // chip never waits
  assign cpu_ready  = ~chip_valid;
  assign ram_en     = (grant != NONE);
  assign ram_req    = (grant == CHIP) ? chip_req : cpu_req;
  assign rd_owner   = (ram_en && !ram_req.we) ? grant : NONE;

  //////////////////////////////////////////////////
  // owner tags and response routing
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_ram <= NONE;
      tag_rsp <= NONE;
    end else begin
      tag_ram <= rd_owner;
      tag_rsp <= tag_ram;                       // two reads can overlap
    end
  end

  always_ff @(posedge clk) begin
    if (tag_ram != NONE) begin
      rdata_q <= ram_rdata;
    end
  end

  assign chip_rsp_valid = (tag_rsp == CHIP);
  assign cpu_rsp_valid  = (tag_rsp == CPU);
  assign chip_rsp.rdata = rdata_q;              // shared, valid picks the owner
  assign cpu_rsp.rdata  = rdata_q;

  a_rsp_excl: assert property (@(posedge clk) disable iff (rst)
    !(chip_rsp_valid && cpu_rsp_valid))
    else $error("both ports got a response");

endmodule

//--- src/user_io.sv
/*
  spi mode 0 slave for the board controller, oversampled in clk
  sck must stay below clk/4, one hold register for the kbd/mouse stream
*/
`timescale 1ns/10ps
`include "minimig_config.svh"

module user_io import minimig_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       spi_sck,
  input  logic       spi_di,           // mosi
  input  logic       conf_data0,       // select, active low
  input  logic       kbd_mouse_ready,
  output logic       spi_do,           // miso data
  output logic       spi_do_oe,        // miso pad enable
  output joy_t       joy_a,
  output joy_t       joy_b,
  output logic [2:0] mouse_buttons,
  output kbd_mouse_t kbd_mouse,
  output logic       kbd_mouse_valid
);

  logic [1:0] sck_sync;       // [1] is the synced value
  logic [1:0] di_sync;
  logic [1:0] ss_sync;
  logic       sck_d;          // edge detect history
  logic       sck_rise;
  logic       sck_fall;
  logic       sel;
  logic [2:0] bit_cnt;
  logic [6:0] rx_sr;
  logic [7:0] tx_sr;
  logic [7:0] next_byte;      // rx byte including the current bit
  logic [7:0] cmd;
  logic       byte_done;
  logic       payload_done;
  logic       km_load;
  spi_state_t state;

  //////////////////////////////////////////////////
  // synchronizers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      sck_sync <= '0;
      di_sync  <= '0;
      ss_sync  <= 2'b11;                          // deselected
      sck_d    <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[0], spi_sck};
      di_sync  <= {di_sync[0], spi_di};
      ss_sync  <= {ss_sync[0], conf_data0};
      sck_d    <= sck_sync[1];
    end
  end

  assign sel          = ~ss_sync[1];
  assign sck_rise     = sck_sync[1] & ~sck_d;
  assign sck_fall     = ~sck_sync[1] & sck_d;
  assign next_byte    = {rx_sr, di_sync[1]};
  assign byte_done    = sel && sck_rise && (bit_cnt == 3'd7);
  assign payload_done = byte_done && (state == PAYLOAD);
  assign km_load      = payload_done && ((cmd == `CMD_MOUSE) || (cmd == `CMD_KBD)) &&
                        (!kbd_mouse_valid || kbd_mouse_ready);  // drop when full
  assign spi_do       = tx_sr[7];                               // msb first
  assign spi_do_oe    = sel;

  //////////////////////////////////////////////////
  // byte framing fsm and shifters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      bit_cnt <= '0;
      rx_sr   <= '0;
      tx_sr   <= '0;
      cmd     <= '0;
    end else if (!sel) begin
      state   <= IDLE;
      bit_cnt <= '0;
      tx_sr   <= '0;
    end else begin
      if (state == IDLE) begin
        state <= CMD;
        tx_sr <= `CORE_ID;                        // first bit ready before sck rises
      end else if (sck_fall) begin
        tx_sr <= {tx_sr[6:0], 1'b0};              // zeros after the id
      end
      if (sck_rise) begin
        rx_sr   <= next_byte[6:0];
        bit_cnt <= bit_cnt + 3'd1;
      end
      if (byte_done && (state == CMD)) begin
        cmd   <= next_byte;
        state <= PAYLOAD;
      end
    end
  end

  //////////////////////////////////////////////////
  // payload sinks
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      joy_a           <= '0;
      joy_b           <= '0;
      mouse_buttons   <= '0;
      kbd_mouse_valid <= 1'b0;
    end else begin
      if (payload_done && (cmd == `CMD_JOY_A)) begin
        joy_a <= next_byte[5:0];                  // last byte wins
      end
      if (payload_done && (cmd == `CMD_JOY_B)) begin
        joy_b <= next_byte[5:0];
      end
      if (payload_done && (cmd == `CMD_MOUSE_BTN)) begin
        mouse_buttons <= next_byte[2:0];
      end
      if (km_load) begin
        kbd_mouse_valid <= 1'b1;
      end else if (kbd_mouse_ready) begin
        kbd_mouse_valid <= 1'b0;                  // transfer done
      end
    end
  end

  always_ff @(posedge clk) begin
    if (km_load) begin
      kbd_mouse.data <= next_byte;
      kbd_mouse.kind <= (cmd == `CMD_KBD) ? KM_KBD : KM_MOUSE;
    end
  end

  a_km_hold: assert property (@(posedge clk) disable iff (rst)
    kbd_mouse_valid && !kbd_mouse_ready |=> kbd_mouse_valid && $stable(kbd_mouse))
    else $error("kbd_mouse changed while stalled");

endmodule

//--- src/amiga_clk_en.sv
/*
  single-cycle enables for the 28 MHz domain, all registered
  counters restart at zero on reset, first clk7_en one clock after release
*/
`timescale 1ns/10ps
`include "minimig_config.svh"

module amiga_clk_en (
  input  logic clk,        // 28 MHz system clock
  input  logic rst,
  output logic clk7_en,    // 7 MHz rising phase
  output logic clk7n_en,   // 7 MHz falling phase
  output logic c1,         // quadrature, phases 1 and 2
  output logic c3,         // quadrature, phases 2 and 3
  output logic cck,        // colour clock enable
  output logic eclk        // e-clock enable
);

  localparam int unsigned PH_W   = $clog2(`CLK7_DIV);
  localparam int unsigned CCK_N  = `CCK_DIV / `CLK7_DIV;   // 7 MHz periods per cck
  localparam int unsigned ECLK_N = `ECLK_DIV / `CLK7_DIV;  // 7 MHz periods per eclk
  localparam int unsigned CCK_W  = (CCK_N > 1) ? $clog2(CCK_N) : 1;
  localparam int unsigned ECLK_W = (ECLK_N > 1) ? $clog2(ECLK_N) : 1;

  logic [PH_W-1:0]   phase;      // 28 MHz cycle within 7 MHz period
  logic [CCK_W-1:0]  cck_cnt;
  logic [ECLK_W-1:0] eclk_cnt;
  logic              phase_end;  // last cycle of the period

  assign phase_end = (phase == PH_W'(`CLK7_DIV - 1));

  //////////////////////////////////////////////////
  // phase and divider counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      phase    <= '0;
      cck_cnt  <= '0;
      eclk_cnt <= '0;
      clk7_en  <= 1'b0;
      clk7n_en <= 1'b0;
      c1       <= 1'b0;
      c3       <= 1'b0;
      cck      <= 1'b0;
      eclk     <= 1'b0;
    end else begin
      phase    <= phase_end ? '0 : phase + PH_W'(1);
      clk7_en  <= (phase == '0);                        // output lags phase by one
      clk7n_en <= (phase == PH_W'(`CLK7_DIV / 2));
      c1       <= (phase == PH_W'(1)) || (phase == PH_W'(2));
      c3       <= (phase == PH_W'(2)) || (phase == PH_W'(3));
      cck      <= (phase == '0) && (cck_cnt == '0);     // aligned with clk7_en
      eclk     <= (phase == '0) && (eclk_cnt == '0);
      if (phase_end) begin
        cck_cnt  <= (cck_cnt == CCK_W'(CCK_N - 1)) ? '0 : cck_cnt + CCK_W'(1);
        eclk_cnt <= (eclk_cnt == ECLK_W'(ECLK_N - 1)) ? '0 : eclk_cnt + ECLK_W'(1);
      end
    end
  end

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  a_clk7_phase: assert property (@(posedge clk) disable iff (rst)
    clk7_en |-> !clk7n_en ##2 clk7n_en)
    else $error("clk7n_en not half a period after clk7_en");

  a_eclk_cck: assert property (@(posedge clk) disable iff (rst)
    eclk |-> cck && clk7_en)
    else $error("eclk outside a cck slot");

endmodule

//--- src/minimig_pkg.sv
/*
  shared types of the minimig glue
  widths follow minimig_config.svh
*/
`include "minimig_config.svh"

package minimig_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;  // chip ram word address
  typedef logic [`MEM_DATA_W-1:0] mem_data_t;
  typedef logic [1:0]             byte_en_t;   // [1] upper, [0] lower byte
  typedef logic [5:0]             joy_t;       // fire2 fire up down left right

  typedef enum logic [1:0] {
    KM_MOUSE = 2'd0,
    KM_KBD   = 2'd1
  } kbd_mouse_type_t;

  typedef struct packed {
    logic [7:0]      data;    // mouse delta or keycode
    kbd_mouse_type_t kind;    // follows the command byte
  } kbd_mouse_t;

  typedef struct packed {
    mem_addr_t addr;
    mem_data_t wdata;
    byte_en_t  be;
    logic      we;            // write when set
  } mem_req_t;

  typedef struct packed {
    mem_data_t rdata;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    IDLE,                     // deselected
    CMD,                      // first byte after select
    PAYLOAD
  } spi_state_t;

  typedef enum logic [1:0] {
    NONE,
    CHIP,
    CPU
  } arb_owner_t;

endpackage

//--- src/minimig_config.svh
/*
  board-fixed widths, divider counts and command codes
  dividers must be whole multiples of CLK7_DIV
*/
`ifndef MINIMIG_CONFIG_SVH
`define MINIMIG_CONFIG_SVH

// memory geometry
`define MEM_ADDR_W    12        // word address, small model of the chip bus
`define MEM_DATA_W    16

// clk cycles per enable pulse
`define CLK7_DIV      4
`define CCK_DIV       8         // colour clock
`define ECLK_DIV      40        // 6800 e-clock

// user_io command bytes
`define CMD_JOY_A     8'd1
`define CMD_JOY_B     8'd2
`define CMD_MOUSE_BTN 8'd3
`define CMD_MOUSE     8'd4
`define CMD_KBD       8'd5
`define CORE_ID       8'ha1     // minimig core id on miso

`endif
